// File: verilog/temp_display_pkg.sv
// timing constants are sized for simulation; raise serial_half_period and stable_ticks on hardware
`default_nettype none

package temp_display_pkg;

	// ---------------------------------------
	// clock ratios, in clk27 cycles
	// ---------------------------------------
	// half of one serial clock period
	// about 2 MHz at 27 MHz would need 7
	localparam int serial_half_period = 4;
	// key must be steady this long
	// a board wants several ms here
	localparam int stable_ticks = 16;

	// ---------------------------------------
	// widths and counts
	// ---------------------------------------
	// one sensor reading
	localparam int data_bits = 8;
	// three decimal digits cover 255
	localparam int bcd_digits = 3;
	// digits on the led driver
	localparam int num_digits = 8;
	// driver command word
	localparam int word_bits = 16;

	// keys and their index in the key vector
	localparam int num_keys = 3;
	localparam int key_freeze = 0;
	localparam int key_hex = 1;
	localparam int key_humid = 2;

	// ---------------------------------------
	// led driver registers
	// ---------------------------------------
	// digit registers run from 1 to 8
	localparam logic [3:0] reg_digit1 = 4'd1;
	localparam logic [3:0] reg_decode = 4'd9;
	localparam logic [3:0] reg_intensity = 4'd10;
	localparam logic [3:0] reg_scan_limit = 4'd11;
	localparam logic [3:0] reg_shutdown = 4'd12;

	// start-up sequence, sent once after reset
	localparam int init_words = 4;
	// normal operation
	localparam logic [7:0] val_shutdown = 8'h01;
	// scan all eight digits
	localparam logic [7:0] val_scan_limit = 8'h07;
	// raw segments, no code b decoding
	localparam logic [7:0] val_decode = 8'h00;
	// mid brightness
	localparam logic [7:0] val_intensity = 8'h08;

	// segment byte of an unused digit
	localparam logic [7:0] font_blank = 8'h00;

endpackage

`default_nettype wire

// File: verilog/key_debounce.sv
// key_n is active low and asynchronous; press and state follow stable_ticks + 2 cycles after it settles
`timescale 1ns/1ps
`default_nettype none

module key_debounce (
	input  wire  clk27,
	input  wire  arst_n,
	input  wire  key_n,
	output logic press,
	output logic state
);

	// two-flop synchronizer, idles high like a released key
	logic [1:0] sync_q;
	// debounced level, high while pressed
	logic       level;
	// counts samples that differ from level
	logic [$clog2(temp_display_pkg::stable_ticks)-1:0] cnt;
	// synchronized key, active high
	logic       key_now;

	assign key_now = ~sync_q[1];

	// ---------------------------------------
	// synchronizer
	// ---------------------------------------
	always_ff @(posedge clk27 or negedge arst_n) begin
		if (!arst_n) begin
			sync_q <= 2'b11;
		end else begin
			sync_q <= {sync_q[0], key_n};
		end
	end

	// ---------------------------------------
	// stability counter, pulse and toggle
	// ---------------------------------------
	always_ff @(posedge clk27 or negedge arst_n) begin
		if (!arst_n) begin
			cnt   <= '0;
			level <= 1'b0;
			press <= 1'b0;
			state <= 1'b0;
		end else begin
			press <= 1'b0;
			if (key_now == level) begin
				// any bounce restarts the count
				cnt <= '0;
			end else if (cnt == temp_display_pkg::stable_ticks - 1) begin
				cnt   <= '0;
				level <= key_now;
				// only the press edge counts, release is silent
				press <= key_now;
				state <= state ^ key_now;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/bcd_sequencer.sv
// finished pulses data_bits + 2 cycles after start; a start while running restarts the conversion
`timescale 1ns/1ps
`default_nettype none

module bcd_sequencer (
	input  wire  clk27,
	input  wire  arst_n,
	input  wire  start,
	input  wire  [temp_display_pkg::data_bits-1:0] value,
	output logic clear,
	output logic shift_en,
	output logic shift_bit,
	output logic [temp_display_pkg::data_bits-1:0] raw_value,
	output logic finished
);

	// reading being shifted out, msb first
	logic [temp_display_pkg::data_bits-1:0] sreg;
	// shifts done so far in this run
	logic [$clog2(temp_display_pkg::data_bits)-1:0] bit_cnt;

	// next bit into cell 0
	assign shift_bit = sreg[temp_display_pkg::data_bits-1];

	// ---------------------------------------
	// run control
	// ---------------------------------------
	always_ff @(posedge clk27 or negedge arst_n) begin
		if (!arst_n) begin
			clear    <= 1'b0;
			shift_en <= 1'b0;
			bit_cnt  <= '0;
			finished <= 1'b0;
		end else begin
			finished <= 1'b0;
			if (start) begin
				// clear cells first, shifting starts a cycle later
				clear    <= 1'b1;
				shift_en <= 1'b0;
				bit_cnt  <= '0;
			end else if (clear) begin
				clear    <= 1'b0;
				shift_en <= 1'b1;
			end else if (shift_en) begin
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == temp_display_pkg::data_bits - 1) begin
					// last bit goes in on this edge
					shift_en <= 1'b0;
					finished <= 1'b1;
				end
			end
		end
	end

	// ---------------------------------------
	// reading latch and shift register
	// ---------------------------------------
	always_ff @(posedge clk27) begin
		if (start) begin
			raw_value <= value;
			sreg      <= value;
		end else if (shift_en) begin
			sreg <= sreg << 1;
		end
	end

endmodule

`default_nettype wire

// File: verilog/bcd_digit_cell.sv
// one double-dabble digit; carry_out is combinational, so a chain settles within one cycle
`timescale 1ns/1ps
`default_nettype none

module bcd_digit_cell (
	input  wire  clk27,
	input  wire  arst_n,
	input  wire  clear,
	input  wire  shift_en,
	input  wire  carry_in,
	output logic carry_out,
	output logic [3:0] digit
);

	// digit after the add-three step
	logic [3:0] corrected;

	// five or more would pass ten after the shift
	assign corrected = (digit >= 4'd5) ? digit + 4'd3 : digit;
	// top bit moves on into the next decade
	assign carry_out = corrected[3];

	always_ff @(posedge clk27 or negedge arst_n) begin
		if (!arst_n) begin
			digit <= 4'd0;
		end else if (clear) begin
			digit <= 4'd0;
		end else if (shift_en) begin
			// shift left, lower decade or reading bit enters at the bottom
			digit <= {corrected[2:0], carry_in};
		end
	end

endmodule

`default_nettype wire

// File: verilog/ledmatrix.sv
// expects a max7219-style driver with no-decode fonts; one frame may be pending, later updates merge
`timescale 1ns/1ps
`default_nettype none

module ledmatrix (
	input  wire  clk27,
	input  wire  arst_n,
	input  wire  update,
	input  wire  [4*temp_display_pkg::bcd_digits-1:0] bcd_digits,
	input  wire  [temp_display_pkg::data_bits-1:0] raw_value,
	input  wire  show_hex,
	input  wire  freeze,
	input  wire  tx_done,
	input  wire  tx_busy,
	output logic word_valid,
	output logic [temp_display_pkg::word_bits-1:0] word
);

	// init words still going out
	logic init_active;
	// digit words of a frame going out
	logic frame_active;
	// word handed to serial_tx, waiting for done
	logic wait_done;
	// update seen during a frame
	logic pending;
	// init word or digit index
	logic [$clog2(temp_display_pkg::num_digits)-1:0] idx;
	logic active;
	logic frame_start;

	// frame data, taken at frame start
	logic [4*temp_display_pkg::bcd_digits-1:0] frame_bcd;
	logic [temp_display_pkg::data_bits-1:0] frame_raw;
	logic frame_hex;

	logic [3:0] dig0;
	logic [3:0] dig1;
	logic [3:0] dig2;
	logic [3:0] init_addr;
	logic [7:0] init_value;
	logic [3:0] digit_addr;
	logic [7:0] seg_byte;

	// ---------------------------------------
	// font, bit 7 dp then segments a to g
	// ---------------------------------------
	function automatic logic [7:0] seg_font(input logic [3:0] nib);
		logic [7:0] seg;
		case (nib)
			4'h0: seg = 8'h7e;
			4'h1: seg = 8'h30;
			4'h2: seg = 8'h6d;
			4'h3: seg = 8'h79;
			4'h4: seg = 8'h33;
			4'h5: seg = 8'h5b;
			4'h6: seg = 8'h5f;
			4'h7: seg = 8'h70;
			4'h8: seg = 8'h7f;
			4'h9: seg = 8'h7b;
			4'ha: seg = 8'h77;
			4'hb: seg = 8'h1f;
			4'hc: seg = 8'h4e;
			4'hd: seg = 8'h3d;
			4'he: seg = 8'h4f;
			default: seg = 8'h47;
		endcase
		return seg;
	endfunction

	assign active = init_active | frame_active;
	// a pending frame goes first, fresh updates only when not frozen
	assign frame_start = !active && (pending || (update && !freeze));

	// ones, tens, hundreds
	assign dig0 = frame_bcd[3:0];
	assign dig1 = frame_bcd[7:4];
	assign dig2 = frame_bcd[11:8];

	// ---------------------------------------
	// word contents
	// ---------------------------------------
	always_comb begin
		case (idx)
			3'd0: begin
				init_addr  = temp_display_pkg::reg_shutdown;
				init_value = temp_display_pkg::val_shutdown;
			end
			3'd1: begin
				init_addr  = temp_display_pkg::reg_scan_limit;
				init_value = temp_display_pkg::val_scan_limit;
			end
			3'd2: begin
				init_addr  = temp_display_pkg::reg_decode;
				init_value = temp_display_pkg::val_decode;
			end
			default: begin
				init_addr  = temp_display_pkg::reg_intensity;
				init_value = temp_display_pkg::val_intensity;
			end
		endcase
	end

	always_comb begin
		seg_byte = temp_display_pkg::font_blank;
		if (frame_hex) begin
			// low nibble on digit 1
			if (idx == 3'd0) begin
				seg_byte = seg_font(frame_raw[3:0]);
			end else if (idx == 3'd1) begin
				seg_byte = seg_font(frame_raw[7:4]);
			end
		end else begin
			case (idx)
				3'd0: seg_byte = seg_font(dig0);
				// tens blank only below ten
				3'd1: if (dig2 != 4'd0 || dig1 != 4'd0) seg_byte = seg_font(dig1);
				3'd2: if (dig2 != 4'd0) seg_byte = seg_font(dig2);
				default: seg_byte = temp_display_pkg::font_blank;
			endcase
		end
	end

	// digit 1 is the rightmost register
	assign digit_addr = temp_display_pkg::reg_digit1 + 4'(idx);
	assign word = {4'h0, init_active ? init_addr : digit_addr,
		init_active ? init_value : seg_byte};

	// ---------------------------------------
	// sequencing
	// ---------------------------------------
	always_ff @(posedge clk27 or negedge arst_n) begin
		if (!arst_n) begin
			init_active  <= 1'b1;
			frame_active <= 1'b0;
			wait_done    <= 1'b0;
			pending      <= 1'b0;
			idx          <= '0;
			word_valid   <= 1'b0;
		end else begin
			word_valid <= 1'b0;
			// remember one update that arrives while busy
			if (active && update && !freeze) begin
				pending <= 1'b1;
			end
			if (frame_start) begin
				frame_active <= 1'b1;
				idx          <= '0;
				pending      <= 1'b0;
			end
			if (active && !wait_done && !tx_busy) begin
				word_valid <= 1'b1;
				wait_done  <= 1'b1;
			end else if (wait_done && tx_done) begin
				wait_done <= 1'b0;
				if (init_active && idx == temp_display_pkg::init_words - 1) begin
					init_active <= 1'b0;
					idx         <= '0;
				end else if (frame_active && idx == temp_display_pkg::num_digits - 1) begin
					frame_active <= 1'b0;
					idx          <= '0;
				end else begin
					idx <= idx + 1'b1;
				end
			end
		end
	end

	// snapshot so a frame stays consistent while the next conversion runs
	always_ff @(posedge clk27) begin
		if (frame_start) begin
			frame_bcd <= bcd_digits;
			frame_raw <= raw_value;
			frame_hex <= show_hex;
		end
	end

endmodule

`default_nettype wire

// File: verilog/serial_tx.sv
// sends one word msb first, 33 half periods; word_valid is dropped while busy
`timescale 1ns/1ps
`default_nettype none

module serial_tx (
	input  wire  clk27,
	input  wire  arst_n,
	input  wire  word_valid,
	input  wire  [temp_display_pkg::word_bits-1:0] word,
	output logic done,
	output logic busy,
	output logic seg_clk,
	output logic seg_dat,
	output logic seg_sel
);

	// clk27 cycles within a half period
	logic [$clog2(temp_display_pkg::serial_half_period)-1:0] div;
	// half period index, even low and odd high, last one is the load
	logic [$clog2(2*temp_display_pkg::word_bits+1)-1:0] phase;
	logic [temp_display_pkg::word_bits-1:0] sreg;
	logic load;
	logic tick;
	logic bit_end;
	logic last_half;

	assign load = word_valid && !busy;
	assign tick = busy && (div == temp_display_pkg::serial_half_period - 1);
	// end of a high half, clock falls
	assign bit_end = tick && phase[0];
	// high half of bit 0
	assign last_half = (phase == 2*temp_display_pkg::word_bits - 1);

	// ---------------------------------------
	// divider, bit count and pins
	// ---------------------------------------
	always_ff @(posedge clk27 or negedge arst_n) begin
		if (!arst_n) begin
			div     <= '0;
			phase   <= '0;
			busy    <= 1'b0;
			done    <= 1'b0;
			seg_clk <= 1'b0;
			seg_dat <= 1'b0;
			seg_sel <= 1'b1;
		end else begin
			done <= 1'b0;
			if (load) begin
				busy    <= 1'b1;
				div     <= '0;
				phase   <= '0;
				seg_sel <= 1'b0;
				seg_clk <= 1'b0;
				// msb is set up during the first low half
				seg_dat <= word[temp_display_pkg::word_bits-1];
			end else if (busy) begin
				if (tick) begin
					div <= '0;
					if (phase == 2*temp_display_pkg::word_bits) begin
						// load half over
						busy <= 1'b0;
						done <= 1'b1;
					end else begin
						phase   <= phase + 1'b1;
						seg_clk <= ~phase[0];
						if (phase[0]) begin
							if (last_half) begin
								// rising select latches the word
								seg_sel <= 1'b1;
								seg_dat <= 1'b0;
							end else begin
								seg_dat <= sreg[temp_display_pkg::word_bits-2];
							end
						end
					end
				end else begin
					div <= div + 1'b1;
				end
			end
		end
	end

	// ---------------------------------------
	// shift register
	// ---------------------------------------
	always_ff @(posedge clk27) begin
		if (load) begin
			sreg <= word;
		end else if (bit_end && !last_half) begin
			sreg <= sreg << 1;
		end
	end

endmodule

`default_nettype wire

// File: verilog/temp_display.sv
// sensor readings come in already sampled with sample_valid; keys are active low, leds active low
`timescale 1ns/1ps
`default_nettype none

module temp_display (
	input  wire  clk27,
	input  wire  arst_n,
	input  wire  [temp_display_pkg::num_keys-1:0] key_n,
	input  wire  sample_valid,
	input  wire  [temp_display_pkg::data_bits-1:0] humid,
	input  wire  [temp_display_pkg::data_bits-1:0] temp,
	output logic seg_dat,
	output logic seg_sel,
	output logic seg_clk,
	output logic [3:0] led
);

	// key outputs, indexed by the package key numbers
	logic [temp_display_pkg::num_keys-1:0] key_press;
	logic [temp_display_pkg::num_keys-1:0] key_state;
	logic freeze;
	logic show_hex;
	logic show_humid;

	// conversion
	logic [temp_display_pkg::data_bits-1:0] reading;
	logic [temp_display_pkg::data_bits-1:0] bcd_raw;
	logic bcd_start;
	logic bcd_clear;
	logic bcd_shift_en;
	logic bcd_finished;
	// carry chain, bit 0 is the reading bit, top bit overflows past 999
	logic [temp_display_pkg::bcd_digits:0] carry;
	logic [4*temp_display_pkg::bcd_digits-1:0] bcd_value;

	// driver bus
	logic tx_valid;
	logic [temp_display_pkg::word_bits-1:0] tx_word;
	logic tx_done;
	logic tx_busy;

	// ---------------------------------------
	// keys
	// ---------------------------------------
	for (genvar g = 0; g < temp_display_pkg::num_keys; g++) begin : g_key
		key_debounce u_key (
			.clk27  (clk27),
			.arst_n (arst_n),
			.key_n  (key_n[g]),
			.press  (key_press[g]),
			.state  (key_state[g])
		);
	end

	assign freeze     = key_state[temp_display_pkg::key_freeze];
	assign show_hex   = key_state[temp_display_pkg::key_hex];
	assign show_humid = key_state[temp_display_pkg::key_humid];

	// ---------------------------------------
	// bcd conversion
	// ---------------------------------------
	assign reading = show_humid ? humid : temp;
	// mode changes reconvert so the display follows at once
	assign bcd_start = sample_valid | key_press[temp_display_pkg::key_hex]
		| key_press[temp_display_pkg::key_humid];

	bcd_sequencer u_seq (
		.clk27     (clk27),
		.arst_n    (arst_n),
		.start     (bcd_start),
		.value     (reading),
		.clear     (bcd_clear),
		.shift_en  (bcd_shift_en),
		.shift_bit (carry[0]),
		.raw_value (bcd_raw),
		.finished  (bcd_finished)
	);

	for (genvar d = 0; d < temp_display_pkg::bcd_digits; d++) begin : g_cell
		bcd_digit_cell u_cell (
			.clk27     (clk27),
			.arst_n    (arst_n),
			.clear     (bcd_clear),
			.shift_en  (bcd_shift_en),
			.carry_in  (carry[d]),
			.carry_out (carry[d+1]),
			.digit     (bcd_value[4*d +: 4])
		);
	end

	// ---------------------------------------
	// led driver
	// ---------------------------------------
	ledmatrix u_matrix (
		.clk27      (clk27),
		.arst_n     (arst_n),
		.update     (bcd_finished),
		.bcd_digits (bcd_value),
		.raw_value  (bcd_raw),
		.show_hex   (show_hex),
		.freeze     (freeze),
		.tx_done    (tx_done),
		.tx_busy    (tx_busy),
		.word_valid (tx_valid),
		.word       (tx_word)
	);

	serial_tx u_tx (
		.clk27      (clk27),
		.arst_n     (arst_n),
		.word_valid (tx_valid),
		.word       (tx_word),
		.done       (tx_done),
		.busy       (tx_busy),
		.seg_clk    (seg_clk),
		.seg_dat    (seg_dat),
		.seg_sel    (seg_sel)
	);

	// status leds, lit when low
	assign led[0] = ~tx_busy;
	assign led[1] = ~freeze;
	assign led[2] = ~show_hex;
	assign led[3] = ~show_humid;

endmodule

`default_nettype wire

// File: sim/tb_temp_display.sv
// reads sim/temp_display_golden.txt from the project root; timing assumes the simulation constants
`timescale 1ns/1ps
`default_nettype none

module tb_temp_display;

	// cycles allowed for one word including the conversion and a pending frame
	localparam int word_limit = 1200;
	// cycles allowed for the driver to go idle
	localparam int idle_limit = 400;
	// how long a frozen display must stay silent
	localparam int quiet_cycles = 1500;
	// key held low and then high well past the debounce count
	localparam int key_hold = temp_display_pkg::stable_ticks + 8;

	logic clk27;
	logic arst_n;
	logic [temp_display_pkg::num_keys-1:0] key_n;
	logic sample_valid;
	logic [temp_display_pkg::data_bits-1:0] humid;
	logic [temp_display_pkg::data_bits-1:0] temp;
	logic seg_dat;
	logic seg_sel;
	logic seg_clk;
	logic [3:0] led;

	int value_errors;
	int timeouts;
	int misc_errors;
	int checks;

	// word monitor state
	logic clk_q;
	logic sel_q;
	logic [temp_display_pkg::word_bits-1:0] shift_word;
	int bit_count;
	logic [temp_display_pkg::word_bits-1:0] words_q[$];
	// expected segment bytes with eight per frame
	logic [7:0] exp_q[$];

	temp_display u_dut (
		.clk27        (clk27),
		.arst_n       (arst_n),
		.key_n        (key_n),
		.sample_valid (sample_valid),
		.humid        (humid),
		.temp         (temp),
		.seg_dat      (seg_dat),
		.seg_sel      (seg_sel),
		.seg_clk      (seg_clk),
		.led          (led)
	);

	initial clk27 = 1'b0;
	always #20 clk27 = ~clk27;

	// ----------------------------------------
	// serial word decoder
	// ----------------------------------------
	always @(posedge clk27 or negedge arst_n) begin
		if (!arst_n) begin
			clk_q      <= 1'b0;
			sel_q      <= 1'b1;
			shift_word <= '0;
			bit_count  <= 0;
		end else begin
			clk_q <= seg_clk;
			sel_q <= seg_sel;
			// data is valid at the rising serial clock
			if (seg_clk && !clk_q) begin
				shift_word <= {shift_word[temp_display_pkg::word_bits-2:0], seg_dat};
				bit_count  <= bit_count + 1;
			end
			// rising select closes the word
			if (seg_sel && !sel_q) begin
				words_q.push_back(shift_word);
				if (bit_count != temp_display_pkg::word_bits) begin
					misc_errors++;
					$display("word closed after %0d serial bits instead of %0d", bit_count,
						temp_display_pkg::word_bits);
				end
				bit_count <= 0;
			end
		end
	end

	// ----------------------------------------
	// compare tasks
	// ----------------------------------------
	task automatic check_word(input logic [temp_display_pkg::word_bits-1:0] expected,
		input logic [temp_display_pkg::word_bits-1:0] got, input int n);
		checks++;
		if (got !== expected) begin
			value_errors++;
			$display("Fail %0t: init word %0d is %h, expected %h", $time, n, got, expected);
		end
	endtask

	task automatic check_digit(input logic [3:0] exp_addr, input logic [7:0] exp_seg,
		input logic [temp_display_pkg::word_bits-1:0] got);
		checks++;
		if (got !== {4'h0, exp_addr, exp_seg}) begin
			value_errors++;
			$display("Fail %0t: digit %0d word is %h, expected segments %h", $time, exp_addr,
				got, exp_seg);
		end
	endtask

	task automatic check_led(input logic [3:0] expected, input logic [3:0] got);
		checks++;
		if (got !== expected) begin
			value_errors++;
			$display("Fail %0t: led is %b, expected %b", $time, got, expected);
		end
	endtask

	// ----------------------------------------
	// waits with their own limits
	// ----------------------------------------
	task automatic wait_word(output logic ok);
		int cnt;
		cnt = 0;
		ok = 1'b1;
		while (words_q.size() == 0) begin
			@(posedge clk27);
			cnt++;
			if (cnt > word_limit) begin
				timeouts++;
				$display("timeout: no word from the display within %0d cycles", word_limit);
				ok = 1'b0;
				break;
			end
		end
	endtask

	task automatic wait_idle();
		int cnt;
		cnt = 0;
		// led 0 is high while the serial driver is idle
		while (led[0] !== 1'b1) begin
			@(posedge clk27);
			cnt++;
			if (cnt > idle_limit) begin
				timeouts++;
				$display("timeout: serial driver still busy after %0d cycles", idle_limit);
				break;
			end
		end
	endtask

	task automatic wait_busy();
		int cnt;
		cnt = 0;
		while (seg_sel !== 1'b0) begin
			@(posedge clk27);
			cnt++;
			if (cnt > word_limit) begin
				timeouts++;
				$display("timeout: no word started within %0d cycles", word_limit);
				break;
			end
		end
	endtask

	task automatic expect_quiet();
		int cnt;
		for (cnt = 0; cnt < quiet_cycles; cnt++) begin
			@(posedge clk27);
			if (words_q.size() != 0 || seg_sel !== 1'b1) begin
				misc_errors++;
				$display("display sent a word while frozen");
				words_q.delete();
				break;
			end
		end
	endtask

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	task automatic drive_sample(input logic [7:0] t, input logic [7:0] h);
		@(posedge clk27);
		temp         <= t;
		humid        <= h;
		sample_valid <= 1'b1;
		@(posedge clk27);
		sample_valid <= 1'b0;
	endtask

	task automatic press_key(input int k);
		@(posedge clk27);
		key_n[k] <= 1'b0;
		repeat (key_hold) @(posedge clk27);
		key_n[k] <= 1'b1;
		repeat (key_hold) @(posedge clk27);
	endtask

	// every queued frame in digit order 1 to 8 and then the idle leds
	task automatic check_frames(input logic [3:0] exp_led);
		logic ok;
		logic [temp_display_pkg::word_bits-1:0] got;
		int i;
		while (exp_q.size() >= temp_display_pkg::num_digits) begin
			for (i = 0; i < temp_display_pkg::num_digits; i++) begin
				wait_word(ok);
				if (!ok) begin
					exp_q.delete();
					return;
				end
				got = words_q.pop_front();
				check_digit(4'(i + 1), exp_q.pop_front(), got);
			end
		end
		wait_idle();
		check_led(exp_led, led);
	endtask

	task automatic run_init(input logic [3:0] exp_led, input logic [7:0] bytes[8]);
		logic ok;
		logic [temp_display_pkg::word_bits-1:0] got;
		int i;
		wait_busy();
		// only led 0 drops while a word goes out
		check_led({exp_led[3:1], 1'b0}, led);
		for (i = 0; i < temp_display_pkg::init_words; i++) begin
			wait_word(ok);
			if (!ok) begin
				return;
			end
			got = words_q.pop_front();
			check_word({bytes[2*i], bytes[2*i+1]}, got, i);
		end
		wait_idle();
		check_led(exp_led, led);
	endtask

	// ----------------------------------------
	// golden file steps
	// ----------------------------------------
	task automatic run_golden();
		int fd;
		int n;
		int i;
		int gap;
		string line;
		logic [8*16-1:0] action;
		logic [7:0] op_a;
		logic [7:0] op_b;
		logic [3:0] exp_led;
		logic [3:0] hold;
		logic [7:0] bytes[8];
		fd = $fopen("sim/temp_display_golden.txt", "r");
		if (fd == 0) begin
			misc_errors++;
			$display("cannot open sim/temp_display_golden.txt");
			return;
		end
		while ($fgets(line, fd) > 0) begin
			// comment and blank lines
			if (line.len() < 2 || line.getc(0) == "#") begin
				continue;
			end
			n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h", action, op_a, op_b,
				exp_led, hold, bytes[0], bytes[1], bytes[2], bytes[3], bytes[4], bytes[5],
				bytes[6], bytes[7]);
			if (n != 13) begin
				misc_errors++;
				$display("malformed golden line: %s", line);
				continue;
			end
			gap = $urandom % 8;
			repeat (gap) @(posedge clk27);
			if (action == "init") begin
				run_init(exp_led, bytes);
			end else if (action == "sample") begin
				drive_sample(op_a, op_b);
				for (i = 0; i < temp_display_pkg::num_digits; i++) begin
					exp_q.push_back(bytes[i]);
				end
				// hold 0 leaves the frame running so the next sample overlaps it
				if (hold != 4'd0) begin
					check_frames(exp_led);
				end else begin
					wait_busy();
				end
			end else if (action == "press") begin
				press_key(int'(op_a));
				// freeze only flips a mode while the other keys reconvert
				if (op_a != temp_display_pkg::key_freeze) begin
					for (i = 0; i < temp_display_pkg::num_digits; i++) begin
						exp_q.push_back(bytes[i]);
					end
				end
				check_frames(exp_led);
			end else if (action == "sample_frozen") begin
				drive_sample(op_a, op_b);
				expect_quiet();
				wait_idle();
				check_led(exp_led, led);
			end else begin
				misc_errors++;
				$display("unknown golden action in line: %s", line);
			end
		end
		$fclose(fd);
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		arst_n       <= 1'b0;
		key_n        <= '1;
		sample_valid <= 1'b0;
		humid        <= '0;
		temp         <= '0;
		value_errors = 0;
		timeouts     = 0;
		misc_errors  = 0;
		checks       = 0;
		void'($urandom(34));
		repeat (8) @(posedge clk27);
		arst_n <= 1'b1;
		run_golden();
		if (words_q.size() != 0) begin
			misc_errors++;
			$display("%0d unexpected words left at the end", words_q.size());
		end
		$display("checks %0d, wrong values %0d, timeouts %0d, other errors %0d", checks,
			value_errors, timeouts, misc_errors);
		if (value_errors == 0 && timeouts == 0 && misc_errors == 0 && checks > 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/temp_display_golden.txt
# columns: action op_a op_b led hold d1 d2 d3 d4 d5 d6 d7 d8, all numbers in hex
# sample: op_a temp, op_b humid; press: op_a key index; init: d1..d8 are address/value pairs
init          00 00 f 1 0c 01 0b 07 09 00 0a 08
sample        00 00 f 1 7e 00 00 00 00 00 00 00
sample        07 00 f 1 70 00 00 00 00 00 00 00
sample        0a 00 f 1 7e 30 00 00 00 00 00 00
sample        2a 00 f 1 6d 33 00 00 00 00 00 00
sample        64 00 f 1 7e 7e 30 00 00 00 00 00
sample        ff 00 f 1 5b 5b 6d 00 00 00 00 00
sample        2a 37 f 1 6d 33 00 00 00 00 00 00
press         01 00 b 1 77 6d 00 00 00 00 00 00
press         02 00 3 1 70 79 00 00 00 00 00 00
press         01 00 7 1 5b 5b 00 00 00 00 00 00
press         02 00 f 1 6d 33 00 00 00 00 00 00
press         00 00 d 1 00 00 00 00 00 00 00 00
sample_frozen 63 00 d 1 00 00 00 00 00 00 00 00
press         00 00 f 1 00 00 00 00 00 00 00 00
sample        63 00 f 1 7b 7b 00 00 00 00 00 00
sample        11 00 f 0 70 30 00 00 00 00 00 00
sample        80 00 f 1 7f 6d 30 00 00 00 00 00

// File: sim.f
verilog/temp_display_pkg.sv
verilog/key_debounce.sv
verilog/bcd_sequencer.sv
verilog/bcd_digit_cell.sv
verilog/ledmatrix.sv
verilog/serial_tx.sv
verilog/temp_display.sv
sim/tb_temp_display.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_temp_display \
	-f sim.f -o tb_temp_display || { echo "build failed"; exit 1; }
./obj_dir/tb_temp_display | tee /dev/stderr | grep -q "Simulation finished: PASS" \
	&& echo "run passed" \
	|| { echo "run failed"; exit 1; }
